//--- design/daq_pkg.sv
package daq_pkg;

    ////////////////////
    // control word layout
    ////////////////////
    localparam int CMD_W  = 16;             // one word from the command path
    localparam int OPC_W  = 4;              // opcode in the top nibble
    localparam int DATA_W = CMD_W - OPC_W;  // data field, low 12 bits

    // opcodes, anything else is dropped
    localparam logic [OPC_W-1:0] OPC_DAC0        = 4'd1;
    localparam logic [OPC_W-1:0] OPC_DAC1        = 4'd2;
    localparam logic [OPC_W-1:0] OPC_DAC2        = 4'd3;
    localparam logic [OPC_W-1:0] OPC_HEADER      = 4'd4;
    localparam logic [OPC_W-1:0] OPC_CTEST       = 4'd5;   // clear / all / single chn
    localparam logic [OPC_W-1:0] OPC_ASIC_NUM    = 4'd6;
    localparam logic [OPC_W-1:0] OPC_ACQ_TIME    = 4'd7;
    localparam logic [OPC_W-1:0] OPC_READOUT_CHN = 4'd8;   // 1 -> chain 1, 0 -> chain 2
    localparam logic [OPC_W-1:0] OPC_SC_LOAD     = 4'd9;
    localparam logic [OPC_W-1:0] OPC_ACQ_START   = 4'd10;
    localparam logic [OPC_W-1:0] OPC_ACQ_STOP    = 4'd11;

    ////////////////////
    // microroc parameter fields
    ////////////////////
    localparam int DAC_W      = 10;  // discriminator threshold
    localparam int HEADER_W   = 8;
    localparam int CTEST_CHNS = 64;  // one test cap per channel
    localparam int CHN_IDX_W  = 6;
    localparam int ASIC_NUM_W = 3;   // n means n+1 asics on the chain
    localparam int ACQ_TIME_W = 12;  // in clk_40m cycles

    ////////////////////
    // slow control frame
    ////////////////////
    localparam int FRAME_BITS    = HEADER_W + 3 * DAC_W + CTEST_CHNS;  // 102 per asic
    localparam int SR_HALF       = 2;  // sr_ck half period in clk_40m cycles
    localparam int SR_RST_CYCLES = 4;  // sr_rstb low time before shifting

    // counter widths for the shifter
    localparam int DIV_W     = $clog2(2 * SR_HALF);
    localparam int BIT_CNT_W = $clog2(FRAME_BITS);
    localparam int RST_CNT_W = $clog2(SR_RST_CYCLES);

endpackage

//--- design/cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder (
    input  logic                             clk_40m,
    input  logic                             rst_n,
    input  logic                             cmd_valid,    // one cycle strobe per word
    input  logic [daq_pkg::CMD_W-1:0]        cmd_word,
    output logic [daq_pkg::DAC_W-1:0]        dac0,
    output logic [daq_pkg::DAC_W-1:0]        dac1,
    output logic [daq_pkg::DAC_W-1:0]        dac2,
    output logic [daq_pkg::HEADER_W-1:0]     header,
    output logic [daq_pkg::CTEST_CHNS-1:0]   ctest,
    output logic [daq_pkg::ASIC_NUM_W-1:0]   asic_num,
    output logic [daq_pkg::ACQ_TIME_W-1:0]   acq_time,
    output logic                             readout_chn,  // 1 chain 1, 0 chain 2
    output logic                             sc_load,      // registered pulse
    output logic                             acq_run       // level, start/stop
);
    import daq_pkg::*;

    logic [OPC_W-1:0]  opc;
    logic [DATA_W-1:0] data;

    // split the word
    assign opc  = cmd_word[CMD_W-1 -: OPC_W];
    assign data = cmd_word[DATA_W-1:0];

    ////////////////////
    // parameter registers
    ////////////////////
    always_ff @(posedge clk_40m or negedge rst_n) begin
        if (!rst_n) begin
            dac0        <= '0;
            dac1        <= '0;
            dac2        <= '0;
            header      <= '0;
            ctest       <= '0;
            asic_num    <= '0;
            acq_time    <= '0;
            readout_chn <= 1'b1;  // chain 1 by default
        end else if (cmd_valid) begin
            case (opc)
                OPC_DAC0:        dac0     <= data[DAC_W-1:0];
                OPC_DAC1:        dac1     <= data[DAC_W-1:0];
                OPC_DAC2:        dac2     <= data[DAC_W-1:0];
                OPC_HEADER:      header   <= data[HEADER_W-1:0];
                OPC_ASIC_NUM:    asic_num <= data[ASIC_NUM_W-1:0];
                OPC_ACQ_TIME:    acq_time <= data[ACQ_TIME_W-1:0];
                OPC_READOUT_CHN: readout_chn <= data[0];
                OPC_CTEST: begin
                    // bit 7 wins over bit 6, both win over the channel index
                    if (data[7]) begin
                        ctest <= '0;                       // clear mask
                    end else if (data[6]) begin
                        ctest <= '1;                       // all 64 channels
                    end else begin
                        ctest[data[CHN_IDX_W-1:0]] <= 1'b1;  // add one chn, keep the rest
                    end
                end
                default: ;  // actions and unknown opcodes touch no parameter
            endcase
        end
    end

    ////////////////////
    // action strobes
    ////////////////////
    always_ff @(posedge clk_40m or negedge rst_n) begin
        if (!rst_n) begin
            sc_load <= 1'b0;
            acq_run <= 1'b0;
        end else begin
            sc_load <= cmd_valid && (opc == OPC_SC_LOAD);  // one cycle only
            if (cmd_valid && opc == OPC_ACQ_START) begin
                acq_run <= 1'b1;
            end else if (cmd_valid && opc == OPC_ACQ_STOP) begin
                acq_run <= 1'b0;  // sequencer still finishes its cycle
            end
        end
    end

endmodule

//--- design/sc_shifter.sv
`timescale 1ns/1ns

module sc_shifter (
    input  logic                             clk_40m,
    input  logic                             rst_n,
    input  logic                             sc_load,
    input  logic [daq_pkg::DAC_W-1:0]        dac0,
    input  logic [daq_pkg::DAC_W-1:0]        dac1,
    input  logic [daq_pkg::DAC_W-1:0]        dac2,
    input  logic [daq_pkg::HEADER_W-1:0]     header,
    input  logic [daq_pkg::CTEST_CHNS-1:0]   ctest,
    input  logic [daq_pkg::ASIC_NUM_W-1:0]   asic_num,
    output logic                             sr_rstb,     // chain register reset, active low
    output logic                             sr_ck,       // chain samples on rising edge
    output logic                             sr_in,
    output logic                             config_done
);
    import daq_pkg::*;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_RST,
        SC_SHIFT
    } sc_state_t;

    sc_state_t             state;
    logic [FRAME_BITS-1:0] frame_snap;  // parameters frozen at load
    logic [FRAME_BITS-1:0] shadow;      // current asic frame, shifts left
    logic [ASIC_NUM_W-1:0] asic_last;   // frozen asic_num
    logic [ASIC_NUM_W-1:0] asic_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [DIV_W-1:0]      div;         // phase inside one sr_ck period
    logic [RST_CNT_W-1:0]  rst_cnt;
    logic                  load_ok;
    logic                  rst_end;
    logic                  half_end;
    logic                  bit_end;
    logic                  frame_end;
    logic                  chain_end;

    assign load_ok   = sc_load && (state == SC_IDLE);  // loads while busy are dropped
    assign rst_end   = (rst_cnt == RST_CNT_W'(SR_RST_CYCLES - 1));
    assign half_end  = (div == DIV_W'(SR_HALF - 1));       // end of low phase
    assign bit_end   = (div == DIV_W'(2 * SR_HALF - 1));   // end of high phase
    assign frame_end = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
    assign chain_end = (asic_cnt == asic_last);

    ////////////////////
    // frame data
    ////////////////////
    always_ff @(posedge clk_40m) begin
        if (load_ok) begin
            // header, dac2, dac1, dac0, then ctest chn 63 down to 0
            frame_snap <= {header, dac2, dac1, dac0, ctest};
            asic_last  <= asic_num;
        end
        if (state == SC_RST && rst_end) begin
            shadow <= frame_snap;            // first asic
        end else if (state == SC_SHIFT && bit_end) begin
            if (frame_end) begin
                shadow <= frame_snap;        // same frame again for next asic
            end else begin
                shadow <= shadow << 1;       // msb out first
            end
        end
    end

    ////////////////////
    // sequencing and pins
    ////////////////////
    always_ff @(posedge clk_40m or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SC_IDLE;
            sr_rstb     <= 1'b1;
            sr_ck       <= 1'b0;
            sr_in       <= 1'b0;
            config_done <= 1'b0;
            rst_cnt     <= '0;
            div         <= '0;
            bit_cnt     <= '0;
            asic_cnt    <= '0;
        end else begin
            config_done <= 1'b0;  // pulse
            case (state)
                SC_IDLE: begin
                    if (load_ok) begin
                        state   <= SC_RST;
                        sr_rstb <= 1'b0;
                        rst_cnt <= '0;
                    end
                end
                SC_RST: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_end) begin
                        state    <= SC_SHIFT;
                        sr_rstb  <= 1'b1;
                        div      <= '0;
                        bit_cnt  <= '0;
                        asic_cnt <= '0;
                        sr_in    <= frame_snap[FRAME_BITS-1];  // first bit while ck low
                    end
                end
                SC_SHIFT: begin
                    div <= div + 1'b1;
                    if (half_end) begin
                        sr_ck <= 1'b1;
                    end
                    if (bit_end) begin
                        sr_ck <= 1'b0;
                        div   <= '0;
                        if (!frame_end) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sr_in   <= shadow[FRAME_BITS-2];   // next bit
                        end else if (!chain_end) begin
                            bit_cnt  <= '0;
                            asic_cnt <= asic_cnt + 1'b1;
                            sr_in    <= frame_snap[FRAME_BITS-1];
                        end else begin
                            state       <= SC_IDLE;         // whole chain written
                            sr_in       <= 1'b0;
                            config_done <= 1'b1;
                        end
                    end
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

endmodule

//--- design/acq_sequencer.sv
`timescale 1ns/1ns

module acq_sequencer (
    input  logic                             clk_40m,
    input  logic                             rst_n,
    input  logic                             acq_run,      // level from decoder
    input  logic [daq_pkg::ACQ_TIME_W-1:0]   acq_time,
    input  logic                             readout_chn,  // 1 chain 1, 0 chain 2
    input  logic                             chipsatb,     // low = chip memory full
    input  logic                             end_readout1,
    input  logic                             end_readout2,
    output logic                             start_acq,
    output logic                             start_readout1,
    output logic                             start_readout2
);
    import daq_pkg::*;

    typedef enum logic [1:0] {
        ACQ_IDLE,
        ACQ_RUN,
        ACQ_RO_REQ,
        ACQ_WAIT_END
    } acq_state_t;

    acq_state_t            state;
    logic [ACQ_TIME_W-1:0] acq_cnt;   // cycles left in the window
    logic [ACQ_TIME_W-1:0] acq_len;
    logic                  chn_sel;   // chain of the pending readout
    logic                  end_hit;
    logic                  win_done;

    assign acq_len  = (acq_time == '0) ? ACQ_TIME_W'(1) : acq_time;  // 0 acts as 1
    assign end_hit  = chn_sel ? end_readout1 : end_readout2;
    assign win_done = (acq_cnt == ACQ_TIME_W'(1)) || !chipsatb;      // timeout or full

    always_ff @(posedge clk_40m or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ACQ_IDLE;
            start_acq      <= 1'b0;
            start_readout1 <= 1'b0;
            start_readout2 <= 1'b0;
            acq_cnt        <= '0;
            chn_sel        <= 1'b1;
        end else begin
            case (state)
                ACQ_IDLE: begin
                    if (acq_run) begin
                        state     <= ACQ_RUN;
                        start_acq <= 1'b1;
                        acq_cnt   <= acq_len;
                    end
                end
                ACQ_RUN: begin
                    acq_cnt <= acq_cnt - 1'b1;
                    if (win_done) begin
                        state          <= ACQ_RO_REQ;
                        start_acq      <= 1'b0;
                        chn_sel        <= readout_chn;   // steer pulse and end select
                        start_readout1 <= readout_chn;
                        start_readout2 <= !readout_chn;
                    end
                end
                ACQ_RO_REQ: begin
                    state          <= ACQ_WAIT_END;  // pulse lasts one cycle
                    start_readout1 <= 1'b0;
                    start_readout2 <= 1'b0;
                end
                ACQ_WAIT_END: begin
                    // stop only takes effect here, never inside a window
                    if (end_hit) begin
                        if (acq_run) begin
                            state     <= ACQ_RUN;
                            start_acq <= 1'b1;
                            acq_cnt   <= acq_len;
                        end else begin
                            state <= ACQ_IDLE;
                        end
                    end
                end
                default: state <= ACQ_IDLE;
            endcase
        end
    end

endmodule

//--- design/microroc_daq_top.sv
`timescale 1ns/1ns

module microroc_daq_top (
    input  logic                        clk_40m,
    input  logic                        rst_n,
    // command path
    input  logic                        cmd_valid,
    input  logic [daq_pkg::CMD_W-1:0]   cmd_word,
    // microroc slow control pins
    output logic                        sr_rstb,
    output logic                        sr_ck,
    output logic                        sr_in,
    output logic                        config_done,
    // daq control pins
    output logic                        start_acq,
    input  logic                        chipsatb,
    output logic                        start_readout1,
    output logic                        start_readout2,
    input  logic                        end_readout1,
    input  logic                        end_readout2
);
    import daq_pkg::*;

    ////////////////////
    // decoded parameters
    ////////////////////
    logic [DAC_W-1:0]      dac0;
    logic [DAC_W-1:0]      dac1;
    logic [DAC_W-1:0]      dac2;
    logic [HEADER_W-1:0]   header;
    logic [CTEST_CHNS-1:0] ctest;
    logic [ASIC_NUM_W-1:0] asic_num;
    logic [ACQ_TIME_W-1:0] acq_time;
    logic                  readout_chn;
    logic                  sc_load;   // to shifter
    logic                  acq_run;   // to sequencer

    cmd_decoder u_decoder (
        .clk_40m     (clk_40m),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .dac0        (dac0),
        .dac1        (dac1),
        .dac2        (dac2),
        .header      (header),
        .ctest       (ctest),
        .asic_num    (asic_num),
        .acq_time    (acq_time),
        .readout_chn (readout_chn),
        .sc_load     (sc_load),
        .acq_run     (acq_run)
    );

    // serial config of the asic chain
    sc_shifter u_shifter (
        .clk_40m     (clk_40m),
        .rst_n       (rst_n),
        .sc_load     (sc_load),
        .dac0        (dac0),
        .dac1        (dac1),
        .dac2        (dac2),
        .header      (header),
        .ctest       (ctest),
        .asic_num    (asic_num),
        .sr_rstb     (sr_rstb),
        .sr_ck       (sr_ck),
        .sr_in       (sr_in),
        .config_done (config_done)
    );

    // acquisition window and readout handshake
    acq_sequencer u_acq (
        .clk_40m        (clk_40m),
        .rst_n          (rst_n),
        .acq_run        (acq_run),
        .acq_time       (acq_time),
        .readout_chn    (readout_chn),
        .chipsatb       (chipsatb),
        .end_readout1   (end_readout1),
        .end_readout2   (end_readout2),
        .start_acq      (start_acq),
        .start_readout1 (start_readout1),
        .start_readout2 (start_readout2)
    );

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input logic                        clk_40m,
    input logic                        rst_n,
    input logic                        cmd_valid,
    input logic [daq_pkg::CMD_W-1:0]   cmd_word,
    input logic                        chipsatb,
    input logic                        end_readout1,
    input logic                        end_readout2,
    input logic                        sr_rstb,
    input logic                        sr_ck,
    input logic                        sr_in,
    input logic                        config_done,
    input logic                        start_acq,
    input logic                        start_readout1,
    input logic                        start_readout2
);
    import daq_pkg::*;

    string                 cur_name = "reset";
    int                    err_cnt = 0;
    int                    n_pass = 0;
    int                    n_fail = 0;

    // parameters as commanded, kept apart from the dut
    logic [DAC_W-1:0]      c_dac0;
    logic [DAC_W-1:0]      c_dac1;
    logic [DAC_W-1:0]      c_dac2;
    logic [HEADER_W-1:0]   c_header;
    logic [CTEST_CHNS-1:0] c_ctest;
    logic [ACQ_TIME_W-1:0] c_acq_time;
    logic                  c_chn;
    logic                  c_run;

    logic [FRAME_BITS-1:0] exp_frame;     // frame of the accepted load
    logic                  sc_busy = 1'b0;
    logic                  prev_ck = 1'b0;
    int                    bit_idx = 0;
    int                    n_bits = 0;
    int                    n_done = 0;
    int                    n_rst_low = 0;

    logic                  in_win = 1'b0;
    logic                  ro_wait = 1'b0;  // readout issued, end not seen yet
    logic                  ro_chn = 1'b1;
    logic                  restart_chk = 1'b0;
    logic                  exp_restart = 1'b0;
    int                    win_cnt = 0;
    int                    win_len = 0;
    int                    exp_w = 0;
    int                    n_wins = 0;
    int                    n_ro = 0;
    int                    since_rst = 0;
    logic                  first_edge = 1'b1;  // dut flops take reset on this edge

    task automatic check_int(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s %s expected %0d actual %0d", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic note_error(input string what);
        $display("%s: %s", cur_name, what);
        err_cnt++;
    endtask

    task automatic begin_test(input string name);
        cur_name  = name;
        err_cnt   = 0;
        n_bits    = 0;
        n_done    = 0;
        n_rst_low = 0;
        n_wins    = 0;
        n_ro      = 0;
    endtask

    task automatic end_test(input int exp_frames, input int exp_wins);
        check_int("shifted bits", exp_frames * FRAME_BITS, n_bits);
        check_int("config_done pulses", (exp_frames > 0) ? 1 : 0, n_done);
        check_int("sr_rstb low cycles", (exp_frames > 0) ? SR_RST_CYCLES : 0, n_rst_low);
        check_int("acq windows", exp_wins, n_wins);
        check_int("readout pulses", exp_wins, n_ro);
        if (err_cnt == 0) begin
            n_pass++;
            $display("done %s: ok", cur_name);
        end else begin
            n_fail++;
            $display("done %s: %0d errors", cur_name, err_cnt);
        end
    endtask

    ////////////////////
    // slow control pins
    ////////////////////
    task automatic watch_shift();
        logic exp_bit;
        if (!sr_rstb) n_rst_low++;
        if (sr_ck && !prev_ck) begin                     // chain samples here
            exp_bit = exp_frame[FRAME_BITS - 1 - (bit_idx % FRAME_BITS)];
            if (!sc_busy) begin
                note_error("sr_ck rose with no load pending");
            end else if (sr_in !== exp_bit) begin
                $display("[FAIL] %s sr_in bit %0d expected %b actual %b",
                         cur_name, bit_idx, exp_bit, sr_in);
                err_cnt++;
            end
            bit_idx++;
            n_bits++;
        end
        prev_ck = sr_ck;
        if (config_done) begin
            n_done++;
            sc_busy = 1'b0;
        end
    endtask

    ////////////////////
    // acquisition pins
    ////////////////////
    task automatic watch_acq();
        if (restart_chk) begin
            restart_chk = 1'b0;
            check_int("start_acq after end_readout", exp_restart, start_acq);
        end
        if (start_acq) begin
            if (!in_win) begin
                in_win  = 1'b1;
                win_cnt = 0;
                exp_w   = 0;
                win_len = (c_acq_time == 0) ? 1 : int'(c_acq_time);  // 0 runs as 1
            end
            win_cnt++;
            // last high cycle: time used up or chip full seen
            if (exp_w == 0 && (!chipsatb || win_cnt == win_len)) exp_w = win_cnt;
        end else if (in_win) begin
            in_win = 1'b0;
            n_wins++;
            check_int("start_acq width", exp_w, win_cnt);
            // {start_readout1, start_readout2}, only the asked chain may pulse
            check_int("readout pins", c_chn ? 2 : 1, {start_readout1, start_readout2});
            ro_wait = 1'b1;
            ro_chn  = c_chn;
        end
        if (start_readout1 || start_readout2) n_ro++;
        if (ro_wait && (ro_chn ? end_readout1 : end_readout2)) begin
            ro_wait     = 1'b0;
            restart_chk = 1'b1;
            exp_restart = c_run;     // next window only while still running
        end
    endtask

    // commands take effect one cycle after the strobe
    task automatic track_cmd();
        logic [OPC_W-1:0]  opc;
        logic [11:0]       data;
        opc  = cmd_word[CMD_W-1 -: OPC_W];
        data = cmd_word[11:0];
        case (opc)
            OPC_DAC0:        c_dac0 = data[DAC_W-1:0];
            OPC_DAC1:        c_dac1 = data[DAC_W-1:0];
            OPC_DAC2:        c_dac2 = data[DAC_W-1:0];
            OPC_HEADER:      c_header = data[HEADER_W-1:0];
            OPC_ACQ_TIME:    c_acq_time = data[ACQ_TIME_W-1:0];
            OPC_READOUT_CHN: c_chn = data[0];
            OPC_ACQ_START:   c_run = 1'b1;
            OPC_ACQ_STOP:    c_run = 1'b0;
            OPC_CTEST: begin
                if (data[7]) c_ctest = '0;
                else if (data[6]) c_ctest = '1;
                else c_ctest[data[5:0]] = 1'b1;
            end
            OPC_SC_LOAD: begin
                if (!sc_busy) begin                  // a load mid-shift is dropped
                    sc_busy   = 1'b1;
                    bit_idx   = 0;
                    // header, dac2, dac1, dac0 msb first, then ctest chn 63 to 0
                    exp_frame = {c_header, c_dac2, c_dac1, c_dac0, c_ctest};
                end
            end
            default: ;
        endcase
    endtask

    always @(posedge clk_40m) begin
        if (!first_edge && (!rst_n || since_rst < 3)) begin
            check_int("idle pins", 7'b1000000, {sr_rstb, sr_ck, sr_in, config_done,
                      start_acq, start_readout1, start_readout2});
        end
        first_edge = 1'b0;
        if (!rst_n) begin
            since_rst  = 0;
            c_dac0     = '0;
            c_dac1     = '0;
            c_dac2     = '0;
            c_header   = '0;
            c_ctest    = '0;
            c_acq_time = '0;
            c_chn      = 1'b1;   // chain 1 out of reset
            c_run      = 1'b0;
            sc_busy    = 1'b0;
            prev_ck    = 1'b0;
            in_win     = 1'b0;
            ro_wait    = 1'b0;
        end else begin
            if (since_rst < 3) since_rst++;
            watch_shift();
            watch_acq();
            if (cmd_valid) track_cmd();
        end
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import daq_pkg::*;

    logic             clk_40m;
    logic             rst_n;
    logic             cmd_valid;
    logic [CMD_W-1:0] cmd_word;
    logic             chipsatb;
    logic             end_readout1;
    logic             end_readout2;
    logic             sr_rstb;
    logic             sr_ck;
    logic             sr_in;
    logic             config_done;
    logic             start_acq;
    logic             start_readout1;
    logic             start_readout2;
    logic [31:0]      lfsr;

    ////////////////////
    // stimulus table
    ////////////////////
    string            row_name   [4];
    logic [CMD_W-1:0] row_cmd    [4][8];
    int               row_ncmd   [4];
    int               row_frames [4];   // asics on the chain, 0 for acq rows
    int               row_reload [4];   // extra load mid-shift
    int               row_wins   [4];
    int               row_ro_dly [4];   // cycles before end_readout
    int               row_sat    [4];   // chip full after n cycles, -1 never

    microroc_daq_top u_dut (
        .clk_40m        (clk_40m),
        .rst_n          (rst_n),
        .cmd_valid      (cmd_valid),
        .cmd_word       (cmd_word),
        .sr_rstb        (sr_rstb),
        .sr_ck          (sr_ck),
        .sr_in          (sr_in),
        .config_done    (config_done),
        .start_acq      (start_acq),
        .chipsatb       (chipsatb),
        .start_readout1 (start_readout1),
        .start_readout2 (start_readout2),
        .end_readout1   (end_readout1),
        .end_readout2   (end_readout2)
    );

    tb_checker u_checker (
        .clk_40m        (clk_40m),
        .rst_n          (rst_n),
        .cmd_valid      (cmd_valid),
        .cmd_word       (cmd_word),
        .chipsatb       (chipsatb),
        .end_readout1   (end_readout1),
        .end_readout2   (end_readout2),
        .sr_rstb        (sr_rstb),
        .sr_ck          (sr_ck),
        .sr_in          (sr_in),
        .config_done    (config_done),
        .start_acq      (start_acq),
        .start_readout1 (start_readout1),
        .start_readout2 (start_readout2)
    );

    always #2 clk_40m = ~clk_40m;  // 4 ns period

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_field(input int nbits, output logic [11:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);   // one step per bit
            val  = {val[10:0], lfsr[0]};
        end
    endtask

    function automatic logic [CMD_W-1:0] make_cmd(input logic [OPC_W-1:0] opc,
                                                  input logic [11:0] data);
        return {opc, data};
    endfunction

    task automatic add_cmd(input int r, input logic [CMD_W-1:0] word);
        row_cmd[r][row_ncmd[r]] = word;
        row_ncmd[r]++;
    endtask

    task automatic build_table();
        logic [11:0] v;
        logic [2:0]  asic_sel;
        row_name[0] = "sc_single";
        rand_field(DAC_W, v);
        add_cmd(0, make_cmd(OPC_DAC0, v));
        rand_field(DAC_W, v);
        add_cmd(0, make_cmd(OPC_DAC1, v));
        rand_field(DAC_W, v);
        add_cmd(0, make_cmd(OPC_DAC2, v));
        rand_field(HEADER_W, v);
        add_cmd(0, make_cmd(OPC_HEADER, v));
        add_cmd(0, make_cmd(OPC_CTEST, 12'd5));            // channel 5 only
        asic_sel = 3'd0;
        add_cmd(0, make_cmd(OPC_ASIC_NUM, {9'd0, asic_sel}));
        add_cmd(0, make_cmd(OPC_SC_LOAD, 12'h000));
        row_frames[0] = int'(asic_sel) + 1;                // n means n+1 asics

        row_name[1] = "sc_multi";
        add_cmd(1, make_cmd(OPC_CTEST, 12'h040));          // all channels
        add_cmd(1, make_cmd(OPC_CTEST, 12'h080));          // clear
        add_cmd(1, make_cmd(OPC_CTEST, 12'd42));
        add_cmd(1, make_cmd(OPC_CTEST, 12'd17));
        rand_field(DAC_W, v);
        add_cmd(1, make_cmd(OPC_DAC1, v));
        rand_field(HEADER_W, v);
        add_cmd(1, make_cmd(OPC_HEADER, v));
        asic_sel = 3'd2;
        add_cmd(1, make_cmd(OPC_ASIC_NUM, {9'd0, asic_sel}));
        add_cmd(1, make_cmd(OPC_SC_LOAD, 12'h000));
        row_frames[1] = int'(asic_sel) + 1;
        row_reload[1] = 1;

        row_name[2] = "acq_chn1";
        add_cmd(2, make_cmd(OPC_ACQ_TIME, 12'd20));
        add_cmd(2, make_cmd(OPC_READOUT_CHN, 12'd1));
        add_cmd(2, make_cmd(OPC_ACQ_START, 12'h000));
        row_wins[2]   = 2;
        row_ro_dly[2] = 5;
        row_sat[2]    = -1;

        row_name[3] = "acq_chn2_stop";
        add_cmd(3, make_cmd(OPC_READOUT_CHN, 12'd0));      // chain 2
        add_cmd(3, make_cmd(OPC_ACQ_TIME, 12'd30));
        add_cmd(3, make_cmd(OPC_ACQ_START, 12'h000));
        row_wins[3]   = 2;
        row_ro_dly[3] = 9;
        row_sat[3]    = 7;
    endtask

    ////////////////////
    // pin level helpers
    ////////////////////
    task automatic tick();
        @(posedge clk_40m);
        #1;                       // drive and look 1 ns after the edge
    endtask

    task automatic send_cmd(input logic [CMD_W-1:0] word);
        cmd_valid = 1'b1;
        cmd_word  = word;
        tick();
        cmd_valid = 1'b0;
    endtask

    function automatic logic pin_val(input int sel);
        case (sel)
            0: return config_done;
            1: return start_acq;
            default: return start_readout1 | start_readout2;
        endcase
    endfunction

    task automatic wait_sig(input int sel, input int limit, input string what);
        int n;
        n = 0;
        while (!pin_val(sel) && n < limit) begin
            tick();
            n++;
        end
        if (!pin_val(sel)) u_checker.note_error({"timed out waiting for ", what});
    endtask

    task automatic run_load(input int r);
        if (row_reload[r] != 0) begin
            repeat (150) tick();
            send_cmd(make_cmd(OPC_SC_LOAD, 12'h000));      // lands mid-shift
        end
        wait_sig(0, row_frames[r] * FRAME_BITS * 2 * SR_HALF + 50, "config_done");
    endtask

    task automatic run_acq(input int r);
        logic chn1;
        for (int w = 0; w < row_wins[r]; w++) begin
            wait_sig(1, 10, "start_acq");
            if (w == row_wins[r] - 1) send_cmd(make_cmd(OPC_ACQ_STOP, 12'h000));
            if (w == 0 && row_sat[r] >= 0) begin
                repeat (row_sat[r]) tick();
                chipsatb = 1'b0;                           // chip memory full
            end
            wait_sig(2, 4200, "start_readout");
            chipsatb = 1'b1;
            chn1     = start_readout1;
            repeat (row_ro_dly[r]) tick();
            end_readout1 = chn1;                           // answer on the asked chain
            end_readout2 = !chn1;
            tick();
            end_readout1 = 1'b0;
            end_readout2 = 1'b0;
        end
    endtask

    initial begin : main
        int r;
        clk_40m      = 1'b0;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_word     = '0;
        chipsatb     = 1'b1;
        end_readout1 = 1'b0;
        end_readout2 = 1'b0;
        lfsr         = 32'd80200;
        u_checker.begin_test("reset");
        build_table();
        repeat (2) @(posedge clk_40m);
        #1;
        rst_n = 1'b1;
        repeat (3) tick();
        u_checker.end_test(0, 0);

        for (r = 0; r < 4; r++) begin
            u_checker.begin_test(row_name[r]);
            for (int c = 0; c < row_ncmd[r]; c++) begin
                send_cmd(row_cmd[r][c]);
            end
            if (row_frames[r] > 0) run_load(r);
            else run_acq(r);
            repeat (40) tick();                            // nothing more may happen
            u_checker.end_test(row_frames[r], row_wins[r]);
        end

        $display("tests %0d, passed %0d, failed %0d",
                 u_checker.n_pass + u_checker.n_fail, u_checker.n_pass, u_checker.n_fail);
        if (u_checker.n_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
design/daq_pkg.sv
design/cmd_decoder.sv
design/sc_shifter.sv
design/acq_sequencer.sv
design/microroc_daq_top.sv
verif/tb_checker.sv
verif/tb_top.sv
